// ==== source/tlb_params.svh ====
`ifndef TLB_PARAMS_SVH
`define TLB_PARAMS_SVH

// address split, 4 KB pages
`define TLB_ADDR_W 48
`define TLB_PAGE_BITS 12
`define TLB_VPN_W (`TLB_ADDR_W - `TLB_PAGE_BITS)

// geometry, index may be 4, 5 or 6
`define TLB_INDEX_BITS 4
`define TLB_SETS (1 << `TLB_INDEX_BITS)
`define TLB_WAYS 4
`define TLB_EPOCH_W 8
`define TLB_ENTRY_W 144

// bus fields
`define TLB_DATA_W 128
`define TLB_OPM_W 16
`define TLB_SEQ_W 16
`define TLB_LDTLB_W 128
// virtual address sits in bits 111:64 of the load-TLB word
`define TLB_LDTLB_VA_LSB 64

// fixed codes on a miss
`define TLB_MISS_PAGE 36'h010
`define TLB_MISS_EXC 16'hA001

`endif

// ==== source/tlbPkg.sv ====
`include "tlb_params.svh"

package tlbPkg;

	// one stored translation, padded out to the entry width
	typedef struct packed {
		logic [`TLB_ENTRY_W - `TLB_EPOCH_W - 2 * `TLB_VPN_W - 2:0] pad;
		logic [`TLB_EPOCH_W-1:0] epoch;
		logic [`TLB_VPN_W-1:0] vpn;
		logic [`TLB_VPN_W-1:0] ppn;
		logic valid;
	} tlbEntry_t;

	// same address word seen as page/offset or as region window
	typedef union packed {
		struct packed {
			logic [`TLB_VPN_W-1:0] vpn;
			logic [`TLB_PAGE_BITS-1:0] offset;
		} page;
		struct packed {
			logic [3:0] nibble;
			logic [`TLB_ADDR_W-5:0] phys;
		} region;
	} l1Addr_u;

	typedef enum logic [2:0] {
		opIdle,
		opLoad,
		opStore,
		opLdtlb,
		opInvtlb,
		opOther
	} opKind_e;

	// low byte of the operation word
	localparam logic [7:0] opmIdle = 8'h00;
	localparam logic [7:0] opmLoad = 8'h90;
	localparam logic [7:0] opmStore = 8'hA0;
	localparam logic [7:0] opmLdtlb = 8'h84;
	localparam logic [7:0] opmInvtlb = 8'h85;

	// physical windows, D is the variant flagged in opm bit 11
	localparam logic [3:0] regionPhys = 4'hC;
	localparam logic [3:0] regionPhysV = 4'hD;

endpackage

// ==== source/tlbLookupIf.sv ====
`timescale 1ns/10ps
`include "tlb_params.svh"

interface tlbLookupIf;
	import tlbPkg::*;

	// read side, index comes straight from the incoming request
	logic [`TLB_INDEX_BITS-1:0] readIndex;
	tlbEntry_t [`TLB_WAYS-1:0] readWays;

	// write side, one-cycle strobe writes a whole set
	logic writeEnable;
	logic [`TLB_INDEX_BITS-1:0] writeIndex;
	tlbEntry_t [`TLB_WAYS-1:0] writeWays;

	modport index (
		output readIndex
	);

	modport store (
		input readIndex, writeEnable, writeIndex, writeWays,
		output readWays
	);

	modport match (
		input readWays,
		output writeEnable, writeIndex, writeWays
	);

endinterface

// ==== source/tlbRequestIf.sv ====
`timescale 1ns/10ps
`include "tlb_params.svh"

interface tlbRequestIf;
	import tlbPkg::*;

	// registered copy of the request
	l1Addr_u addr;
	logic [`TLB_DATA_W-1:0] data;
	logic [`TLB_OPM_W-1:0] opm;
	logic [`TLB_SEQ_W-1:0] seq;
	logic [`TLB_LDTLB_W-1:0] ldtlb;

	// decode results
	opKind_e kind;
	logic translate;
	logic physWin;
	logic physWinV;

	modport source (
		output addr, data, opm, seq, ldtlb, kind, translate, physWin, physWinV
	);

	modport sink (
		input addr, data, opm, seq, ldtlb, kind, translate, physWin, physWinV
	);

endinterface

// ==== source/tlbRequestStage.sv ====
`timescale 1ns/10ps
`include "tlb_params.svh"

module tlbRequestStage (
	input logic clock,
	input logic rst,
	input logic hold,
	input logic mmuEnable,
	input tlbPkg::l1Addr_u inAddr,
	input logic [`TLB_DATA_W-1:0] inData,
	input logic [`TLB_OPM_W-1:0] inOpm,
	input logic [`TLB_SEQ_W-1:0] inSeq,
	input logic [`TLB_LDTLB_W-1:0] inLdtlb,
	tlbLookupIf.index lookup,
	tlbRequestIf.source req
);
	import tlbPkg::*;

	l1Addr_u ldtlbAddr;
	opKind_e nxtKind;
	logic inWin;
	logic inWinV;
	logic nxtTranslate;

	assign ldtlbAddr = inLdtlb[`TLB_LDTLB_VA_LSB +: `TLB_ADDR_W];

	always_comb
	begin
		case (inOpm[7:0])
			opmIdle: nxtKind = opIdle;
			opmLoad: nxtKind = opLoad;
			opmStore: nxtKind = opStore;
			opmLdtlb: nxtKind = opLdtlb;
			opmInvtlb: nxtKind = opInvtlb;
			default: nxtKind = opOther;
		endcase
	end

	// C and D windows are physical already
	assign inWinV = (inAddr.region.nibble == regionPhysV);
	assign inWin = (inAddr.region.nibble == regionPhys) || inWinV;

	assign nxtTranslate = mmuEnable && !inWin &&
		((nxtKind == opLoad) || (nxtKind == opStore));

	// a load-TLB command reads the set it is about to fill
	assign lookup.readIndex = (nxtKind == opLdtlb) ?
		ldtlbAddr.page.vpn[`TLB_INDEX_BITS-1:0] :
		inAddr.page.vpn[`TLB_INDEX_BITS-1:0];

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			req.opm <= '0;
			req.kind <= opIdle;
			req.translate <= 1'b0;
		end
		else if (!hold)
		begin
			req.opm <= inOpm;
			req.kind <= nxtKind;
			req.translate <= nxtTranslate;
		end
	end

	// payload
	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			req.addr <= inAddr;
			req.data <= inData;
			req.seq <= inSeq;
			req.ldtlb <= inLdtlb;
			req.physWin <= inWin;
			req.physWinV <= inWinV;
		end
	end

endmodule

// ==== source/tlbSetStore.sv ====
`timescale 1ns/10ps
`include "tlb_params.svh"

module tlbSetStore (
	input logic clock,
	input logic hold,
	tlbLookupIf.store lookup
);
	import tlbPkg::*;

	// way A is index 0
	tlbEntry_t wayMem [`TLB_WAYS][`TLB_SETS];

	// all entries start invalid
	initial
	begin
		for (int w = 0; w < `TLB_WAYS; w++)
			for (int s = 0; s < `TLB_SETS; s++)
				wayMem[w][s] = '0;
	end

	// read register freezes with the rest of the pipe
	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			for (int w = 0; w < `TLB_WAYS; w++)
				lookup.readWays[w] <= wayMem[w][lookup.readIndex];
		end
	end

	always @(posedge clock)
	begin
		if (lookup.writeEnable)
		begin
			for (int w = 0; w < `TLB_WAYS; w++)
				wayMem[w][lookup.writeIndex] <= lookup.writeWays[w];
		end
	end

	// the matcher must drop its strobe while the pipe is held
	writeNotHeld: assert property (
		@(posedge clock) hold |-> !lookup.writeEnable
	);

endmodule

// ==== source/tlbWayMatch.sv ====
`timescale 1ns/10ps
`include "tlb_params.svh"

module tlbWayMatch (
	input logic clock,
	input logic rst,
	input logic hold,
	tlbRequestIf.sink req,
	tlbLookupIf.match lookup,
	output logic hit,
	output logic [`TLB_VPN_W-1:0] physPage
);
	import tlbPkg::*;

	logic [`TLB_EPOCH_W-1:0] epoch;
	logic wrSuppress;
	logic [`TLB_WAYS-1:0] wayHit;
	logic [`TLB_WAYS-1:0] wayInSet;
	logic [1:0] hitWay;
	logic [1:0] depth;
	logic doWrite;
	l1Addr_u ldtlbAddr;
	tlbEntry_t newEntry;
	tlbEntry_t headEntry;

	assign ldtlbAddr = req.ldtlb[`TLB_LDTLB_VA_LSB +: `TLB_ADDR_W];

	// stale epoch means the entry died in an invalidate
	always_comb
	begin
		for (int w = 0; w < `TLB_WAYS; w++)
			wayHit[w] = lookup.readWays[w].valid &&
				(lookup.readWays[w].epoch == epoch) &&
				(lookup.readWays[w].vpn == req.addr.page.vpn);
	end

	// first hit wins, A before D
	always_comb
	begin
		hitWay = 2'd0;
		for (int w = `TLB_WAYS - 1; w >= 0; w--)
			if (wayHit[w])
				hitWay = 2'(w);
	end

	assign hit = |wayHit;
	assign physPage = lookup.readWays[hitWay].ppn;

	// physical page in bits 47:12 of the load-TLB word
	always_comb
	begin
		newEntry = '0;
		newEntry.epoch = epoch;
		newEntry.vpn = ldtlbAddr.page.vpn;
		newEntry.ppn = req.ldtlb[`TLB_PAGE_BITS +: `TLB_VPN_W];
		newEntry.valid = 1'b1;
	end

	// insert and promote are the same shift,
	// a new entry just pushes all the way down to D
	always_comb
	begin
		headEntry = lookup.readWays[hitWay];
		depth = hitWay;
		doWrite = 1'b0;
		if (req.kind == opLdtlb)
		begin
			headEntry = newEntry;
			depth = 2'd3;
			doWrite = 1'b1;
		end
		else if (req.translate && hit && (hitWay != 2'd0))
			doWrite = 1'b1;
		lookup.writeWays[0] = headEntry;
		for (int w = 1; w < `TLB_WAYS; w++)
			lookup.writeWays[w] = (w <= depth) ?
				lookup.readWays[w-1] : lookup.readWays[w];
	end

	assign lookup.writeIndex = (req.kind == opLdtlb) ?
		ldtlbAddr.page.vpn[`TLB_INDEX_BITS-1:0] :
		req.addr.page.vpn[`TLB_INDEX_BITS-1:0];

	// the request right after a write read the old set contents,
	// so its shuffle would undo the write
	assign lookup.writeEnable = doWrite && !wrSuppress && !hold;

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			epoch <= '0;
			wrSuppress <= 1'b0;
		end
		else if (!hold)
		begin
			wrSuppress <= lookup.writeEnable;
			if (req.kind == opInvtlb)
				epoch <= epoch + 1'b1;
		end
	end

	// a set only ever holds pages that index to it
	always_comb
	begin
		for (int w = 0; w < `TLB_WAYS; w++)
			wayInSet[w] = !lookup.readWays[w].valid ||
				(lookup.readWays[w].vpn[`TLB_INDEX_BITS-1:0] ==
				req.addr.page.vpn[`TLB_INDEX_BITS-1:0]);
	end

	readSetMatches: assert property (
		@(posedge clock) disable iff (rst)
		req.translate |-> &wayInSet
	);

endmodule

// ==== source/tlbOutputStage.sv ====
`timescale 1ns/10ps
`include "tlb_params.svh"

module tlbOutputStage (
	input logic clock,
	input logic rst,
	input logic hold,
	input logic hit,
	input logic [`TLB_VPN_W-1:0] physPage,
	tlbRequestIf.sink req,
	output logic [`TLB_ADDR_W-1:0] outAddr,
	output logic [`TLB_DATA_W-1:0] outData,
	output logic [`TLB_OPM_W-1:0] outOpm,
	output logic [`TLB_SEQ_W-1:0] outSeq,
	output logic [15:0] outExc,
	output logic [`TLB_ADDR_W-1:0] outTea
);
	import tlbPkg::*;

	l1Addr_u nxtAddr;
	logic [`TLB_OPM_W-1:0] nxtOpm;
	logic [15:0] nxtExc;
	logic [`TLB_ADDR_W-1:0] nxtTea;

	always_comb
	begin
		nxtAddr = req.addr;
		nxtOpm = req.opm;
		nxtExc = '0;
		nxtTea = '0;
		if (req.translate)
		begin
			if (hit)
			begin
				nxtAddr.page.vpn = physPage;
				// low physical space maps into the C window
				if (nxtAddr.region.nibble == 4'h0)
					nxtAddr.region.nibble = regionPhys;
			end
			else
			begin
				nxtAddr.page.vpn = `TLB_MISS_PAGE;
				nxtOpm[11:8] = 4'hF;
				nxtExc = `TLB_MISS_EXC;
				nxtTea = req.addr;
			end
		end
		else
		begin
			if (req.physWin)
				nxtAddr.region.nibble = regionPhys;
			if (req.physWinV)
				nxtOpm[11] = 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			outOpm <= '0;
			outExc <= '0;
		end
		else if (!hold)
		begin
			outOpm <= nxtOpm;
			outExc <= nxtExc;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			outAddr <= nxtAddr;
			outData <= req.data;
			outSeq <= req.seq;
			outTea <= nxtTea;
		end
	end

	// window addresses are physical and never reach the translate path
	windowNotTranslated: assert property (
		@(posedge clock) disable iff (rst)
		req.translate |-> !req.physWin
	);

endmodule

// ==== source/tlbMmu.sv ====
`timescale 1ns/10ps
`include "tlb_params.svh"

module tlbMmu (
	input logic clock,
	input logic rst,
	input logic [`TLB_ADDR_W-1:0] inAddr,
	input logic [`TLB_DATA_W-1:0] inData,
	input logic [`TLB_OPM_W-1:0] inOpm,
	input logic [`TLB_SEQ_W-1:0] inSeq,
	input logic [`TLB_LDTLB_W-1:0] inLdtlb,
	input logic mmuEnable,
	input logic hold,
	output logic [`TLB_ADDR_W-1:0] outAddr,
	output logic [`TLB_DATA_W-1:0] outData,
	output logic [`TLB_OPM_W-1:0] outOpm,
	output logic [`TLB_SEQ_W-1:0] outSeq,
	output logic [15:0] outExc,
	output logic [`TLB_ADDR_W-1:0] outTea
);

	logic hit;
	logic [`TLB_VPN_W-1:0] physPage;

	tlbLookupIf lookup ();
	tlbRequestIf req ();

	// stage 1, register and classify
	tlbRequestStage requestStage (
		.clock(clock),
		.rst(rst),
		.hold(hold),
		.mmuEnable(mmuEnable),
		.inAddr(inAddr),
		.inData(inData),
		.inOpm(inOpm),
		.inSeq(inSeq),
		.inLdtlb(inLdtlb),
		.lookup(lookup),
		.req(req)
	);

	tlbSetStore setStore (
		.clock(clock),
		.hold(hold),
		.lookup(lookup)
	);

	// stage 2, match and write back
	tlbWayMatch wayMatch (
		.clock(clock),
		.rst(rst),
		.hold(hold),
		.req(req),
		.lookup(lookup),
		.hit(hit),
		.physPage(physPage)
	);

	tlbOutputStage outputStage (
		.clock(clock),
		.rst(rst),
		.hold(hold),
		.hit(hit),
		.physPage(physPage),
		.req(req),
		.outAddr(outAddr),
		.outData(outData),
		.outOpm(outOpm),
		.outSeq(outSeq),
		.outExc(outExc),
		.outTea(outTea)
	);

endmodule

// ==== sim/tbTlbMmu.sv ====
`timescale 1ns/10ps
`include "tlb_params.svh"

module tbTlbMmu;

	localparam logic [15:0] cmdIdle = 16'h0000;
	localparam logic [15:0] cmdLoad = 16'h0090;
	localparam logic [15:0] cmdStore = 16'h00A0;
	localparam logic [15:0] cmdLoadTlb = 16'h0084;
	localparam logic [15:0] cmdInvalidate = 16'h0085;
	localparam int resetTimeout = 20;

	typedef struct packed {
		logic [15:0] opm;
		logic [47:0] addr;
		logic [127:0] ldtlb;
		logic en;
		logic hold;
		logic [47:0] expAddr;
		logic [3:0] expNib;
		logic [15:0] expExc;
	} stimRow_t;

	// one row on its way through the two pipeline stages
	typedef struct packed {
		stimRow_t row;
		logic [127:0] data;
		logic [15:0] seq;
		logic valid;
	} pipeSlot_t;

	logic clock = 1'b0;
	logic rst;
	logic [`TLB_ADDR_W-1:0] inAddr;
	logic [`TLB_DATA_W-1:0] inData;
	logic [15:0] inOpm;
	logic [15:0] inSeq;
	logic [127:0] inLdtlb;
	logic mmuEnable;
	logic hold;
	logic [`TLB_ADDR_W-1:0] outAddr;
	logic [`TLB_DATA_W-1:0] outData;
	logic [15:0] outOpm;
	logic [15:0] outSeq;
	logic [15:0] outExc;
	logic [`TLB_ADDR_W-1:0] outTea;

	stimRow_t rows[$];
	pipeSlot_t pending;
	pipeSlot_t stage1;
	pipeSlot_t stage2;
	int checkCount;

	tlbMmu dut (.*);

	always #2 clock = ~clock;

	initial
	begin
		rst = 1'b1;
		repeat (4) @(posedge clock);
		#1;
		rst = 1'b0;
	end

	// translated address, page from the entry, offset from the request
	function automatic logic [47:0] hitAddr(input logic [47:0] pa, input logic [47:0] va);
		logic [47:0] a;
		a = {pa[47:12], va[11:0]};
		if (a[47:44] == 4'h0)
			a[47:44] = 4'hC;
		return a;
	endfunction

	function automatic logic [47:0] missAddr(input logic [47:0] va);
		return {`TLB_MISS_PAGE, va[11:0]};
	endfunction

	function automatic void addRow(input logic [15:0] opm, input logic [47:0] addr,
		input logic [127:0] ldtlb, input logic en, input logic hld,
		input logic [47:0] expAddr, input logic [3:0] expNib, input logic [15:0] expExc);
		stimRow_t r;
		r.opm = opm;
		r.addr = addr;
		r.ldtlb = ldtlb;
		r.en = en;
		r.hold = hld;
		r.expAddr = expAddr;
		r.expNib = expNib;
		r.expExc = expExc;
		rows.push_back(r);
	endfunction

	function automatic void addIdle(input int n);
		for (int i = 0; i < n; i++)
			addRow(cmdIdle, 48'h0, 128'h0, 1'b1, 1'b0, 48'h0, 4'h0, 16'h0);
	endfunction

	// inputs during hold are junk and must never be registered
	function automatic void addHold(input int n);
		for (int i = 0; i < n; i++)
			addRow(cmdStore, 48'hDBAD_F00D_0000, 128'h0, 1'b1, 1'b1, 48'h0, 4'h0, 16'h0);
	endfunction

	function automatic void addBypass(input logic [15:0] opm, input logic [47:0] addr,
		input logic en, input logic [47:0] expAddr, input logic [3:0] expNib);
		addRow(opm, addr, 128'h0, en, 1'b0, expAddr, expNib, 16'h0);
	endfunction

	// two idle rows let the set write settle before the next lookup
	function automatic void loadEntry(input logic [47:0] va, input logic [47:0] pa);
		addRow(cmdLoadTlb, 48'h0, {16'h0, va, 16'h0, pa}, 1'b1, 1'b0, 48'h0, 4'h0, 16'h0);
		addIdle(2);
	endfunction

	function automatic void invalidateAll();
		addRow(cmdInvalidate, 48'h0, 128'h0, 1'b1, 1'b0, 48'h0, 4'h0, 16'h0);
		addIdle(2);
	endfunction

	function automatic void expectHit(input logic [15:0] opm, input logic [47:0] va,
		input logic [47:0] pa);
		addRow(opm, va, 128'h0, 1'b1, 1'b0, hitAddr(pa, va), 4'h0, 16'h0);
		addIdle(2);
	endfunction

	function automatic void expectMiss(input logic [47:0] va);
		addRow(cmdLoad, va, 128'h0, 1'b1, 1'b0, missAddr(va), 4'hF, `TLB_MISS_EXC);
		addIdle(2);
	endfunction

	function automatic void buildRows();
		// mmu off, and an enabled op that is neither load nor store
		addBypass(cmdLoad, 48'h1234_5678_9ABC, 1'b0, 48'h1234_5678_9ABC, 4'h0);
		addBypass(cmdStore, 48'h0000_0004_5ABC, 1'b0, 48'h0000_0004_5ABC, 4'h0);
		addBypass(16'h0011, 48'h0000_7777_7123, 1'b1, 48'h0000_7777_7123, 4'h0);
		expectMiss(48'h0000_0004_5ABC);
		loadEntry(48'h0000_0004_5000, 48'h0000_ABCD_E000);
		expectHit(cmdLoad, 48'h0000_0004_5123, 48'h0000_ABCD_E000);
		expectHit(cmdStore, 48'h0000_0004_5FFF, 48'h0000_ABCD_E000);
		loadEntry(48'h0000_0006_6000, 48'h7000_1111_2000);
		expectHit(cmdLoad, 48'h0000_0006_6ABC, 48'h7000_1111_2000);
		// five pages in set 3, the first one falls out of way D
		for (int p = 1; p <= 5; p++)
			loadEntry(48'h0000_0000_3000 | (48'(p) << 20), 48'h0000_0AAA_0000 | (48'(p) << 12));
		expectMiss(48'h0000_0010_3008);
		// promoting page 2 leaves page 3 as the oldest
		expectHit(cmdLoad, 48'h0000_0020_3010, 48'h0000_0AAA_2000);
		loadEntry(48'h0000_0060_3000, 48'h0000_0AAA_6000);
		expectMiss(48'h0000_0030_3020);
		expectHit(cmdLoad, 48'h0000_0020_3024, 48'h0000_0AAA_2000);
		expectHit(cmdLoad, 48'h0000_0040_3030, 48'h0000_0AAA_4000);
		expectHit(cmdStore, 48'h0000_0050_3040, 48'h0000_0AAA_5000);
		expectHit(cmdLoad, 48'h0000_0060_3050, 48'h0000_0AAA_6000);
		expectHit(cmdLoad, 48'h0000_0004_5321, 48'h0000_ABCD_E000);
		invalidateAll();
		expectMiss(48'h0000_0004_5123);
		expectMiss(48'h0000_0006_6ABC);
		expectMiss(48'h0000_0020_3010);
		loadEntry(48'h0000_0004_5000, 48'h0000_0BBB_B000);
		expectHit(cmdLoad, 48'h0000_0004_5456, 48'h0000_0BBB_B000);
		// physical windows, then a stall in the middle of them
		addBypass(cmdLoad, 48'hC123_4567_89AB, 1'b1, 48'hC123_4567_89AB, 4'h0);
		addBypass(cmdLoad, 48'hD000_0000_1234, 1'b1, 48'hC000_0000_1234, 4'h8);
		addBypass(cmdStore, 48'hD0FF_0000_0040, 1'b1, 48'hC0FF_0000_0040, 4'h8);
		addHold(4);
		addBypass(cmdLoad, 48'hC000_0000_0FF0, 1'b1, 48'hC000_0000_0FF0, 4'h0);
		expectHit(cmdLoad, 48'h0000_0004_5789, 48'h0000_0BBB_B000);
		addIdle(2);
	endfunction

	task automatic compareValue(input string name, input logic [127:0] got,
		input logic [127:0] expected);
		if (got !== expected)
		begin
			$display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, expected);
			$display("RESULT: FAIL");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	task automatic waitForReset();
		int cycles;
		cycles = 0;
		while (rst !== 1'b0)
		begin
			@(posedge clock);
			cycles++;
			if (cycles > resetTimeout)
			begin
				$display("reset was still asserted after %0d cycles", cycles);
				$display("RESULT: FAIL");
				$fatal(1, "reset timeout");
			end
		end
	endtask

	// mirrors the edge that just happened, nothing moves under hold
	task automatic advancePipe();
		if (!hold)
		begin
			stage2 = stage1;
			stage1 = pending;
		end
	endtask

	task automatic checkOutputs();
		logic [47:0] expTea;
		logic [15:0] expOpm;
		if (stage2.valid)
		begin
			expTea = (stage2.row.expExc != 16'h0) ? stage2.row.addr : 48'h0;
			expOpm = {stage2.row.opm[15:12], stage2.row.expNib, stage2.row.opm[7:0]};
			compareValue("outAddr", 128'(outAddr), 128'(stage2.row.expAddr));
			compareValue("outOpm", 128'(outOpm), 128'(expOpm));
			compareValue("outExc", 128'(outExc), 128'(stage2.row.expExc));
			compareValue("outTea", 128'(outTea), 128'(expTea));
			compareValue("outData", outData, stage2.data);
			compareValue("outSeq", 128'(outSeq), 128'(stage2.seq));
			checkCount++;
		end
	endtask

	task automatic driveRow(input stimRow_t r, input int idx);
		inOpm = r.opm;
		inAddr = r.addr;
		inLdtlb = r.ldtlb;
		mmuEnable = r.en;
		hold = r.hold;
		inData = {$urandom, $urandom, $urandom, $urandom};
		inSeq = 16'(idx);
		pending.row = r;
		pending.data = inData;
		pending.seq = inSeq;
		pending.valid = 1'b1;
	endtask

	initial
	begin
		// a translated load sits at the inputs all through reset
		inAddr = 48'h0000_0001_2345;
		inData = '0;
		inOpm = cmdLoad;
		inSeq = '0;
		inLdtlb = '0;
		mmuEnable = 1'b1;
		hold = 1'b0;
		pending = '0;
		stage1 = '0;
		stage2 = '0;
		checkCount = 0;
		void'($urandom(32'hddfa));
		buildRows();
		waitForReset();
		#1;
		compareValue("outOpm", 128'(outOpm), 128'h0);
		compareValue("outExc", 128'(outExc), 128'h0);
		inOpm = cmdIdle;
		for (int i = 0; i < rows.size(); i++)
		begin
			@(posedge clock);
			advancePipe();
			#1;
			checkOutputs();
			driveRow(rows[i], i);
		end
		if (checkCount == 0)
		begin
			$display("no table rows reached the outputs");
			$display("RESULT: FAIL");
			$fatal(1, "empty run");
		end
		else
		begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

// ==== verilog.f ====
+incdir+source
source/tlbPkg.sv
source/tlbLookupIf.sv
source/tlbRequestIf.sv
source/tlbRequestStage.sv
source/tlbSetStore.sv
source/tlbWayMatch.sv
source/tlbOutputStage.sv
source/tlbMmu.sv
sim/tbTlbMmu.sv

// ==== Makefile ====
TOP = tbTlbMmu

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o simTlb
	./obj_dir/simTlb

clean:
	rm -rf obj_dir
